// File: rtl/sa_pkg.sv
package sa_pkg;

    localparam int IWIDTH = 8;
    localparam int OWIDTH = 24; // Covers up to 256 rows of full-scale products.

    typedef logic signed [IWIDTH-1:0] act_t;
    typedef logic signed [IWIDTH-1:0] wgt_t;
    typedef logic signed [OWIDTH-1:0] acc_t;

    // Travels along a row together with the serial activation bit.
    typedef struct packed {
        logic bit_vld;
        logic first; // Set on the sign bit.
        logic dbit;
    } row_ctrl_t;

    // One MSB-first step of the bit-serial multiply.
    // The sign bit carries a negative weight in two's complement, so the
    // first step starts from the negated weight.
    function automatic acc_t mac_step(acc_t prod, wgt_t wgt, row_ctrl_t row);
        acc_t addend;
        addend = row.dbit ? acc_t'(wgt) : '0;
        if (row.first) begin
            mac_step = -addend;
        end else begin
            mac_step = (prod <<< 1) + addend;
        end
    endfunction

endpackage

// File: rtl/pe_border.sv
module pe_border (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  logic              act_ld_i,
    input  sa_pkg::act_t      act_i,
    output sa_pkg::row_ctrl_t row_o,

    input  logic              wgt_en_i,
    input  sa_pkg::wgt_t      wgt_i,
    output logic              wgt_en_o,
    output sa_pkg::wgt_t      wgt_o,

    input  logic              drain_en_i,
    input  sa_pkg::acc_t      sum_i,
    output logic              drain_en_o,
    output sa_pkg::acc_t      sum_o
);

    localparam int CNT_W = $clog2(sa_pkg::IWIDTH);

    typedef logic [CNT_W-1:0] bit_cnt_t;

    sa_pkg::act_t      shreg_q;
    bit_cnt_t          bit_cnt_q;
    sa_pkg::row_ctrl_t row_q;
    sa_pkg::wgt_t      wgt_q;
    sa_pkg::acc_t      prod_q;

    assign row_o = row_q;

    // The sign bit goes out in the cycle after the load, the rest follow back to back.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_q     <= '0;
            bit_cnt_q <= '0;
        end else if (act_ld_i) begin
            row_q     <= '{bit_vld: 1'b1, first: 1'b1, dbit: act_i[sa_pkg::IWIDTH-1]};
            bit_cnt_q <= bit_cnt_t'(sa_pkg::IWIDTH - 1);
        end else if (bit_cnt_q != '0) begin
            row_q     <= '{bit_vld: 1'b1, first: 1'b0, dbit: shreg_q[sa_pkg::IWIDTH-1]};
            bit_cnt_q <= bit_cnt_q - 1'b1;
        end else begin
            row_q     <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (act_ld_i) begin
            shreg_q <= act_i << 1; // MSB already sent.
        end else if (bit_cnt_q != '0) begin
            shreg_q <= shreg_q << 1;
        end
    end

    // The border PE multiplies with the same stream it hands to column 1.
    always_ff @(posedge clk_i) begin
        if (row_q.bit_vld) begin
            prod_q <= sa_pkg::mac_step(prod_q, wgt_q, row_q);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wgt_en_o   <= 1'b0;
            drain_en_o <= 1'b0;
        end else begin
            wgt_en_o   <= wgt_en_i;
            drain_en_o <= drain_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wgt_en_i) begin
            wgt_q <= wgt_i;
            wgt_o <= wgt_q; // Previous weight moves one row down.
        end
        if (drain_en_i) begin
            sum_o <= sum_i + prod_q;
        end
    end

endmodule

// File: rtl/pe_inner.sv
module pe_inner (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  sa_pkg::row_ctrl_t row_i,
    output sa_pkg::row_ctrl_t row_o,

    input  logic              wgt_en_i,
    input  sa_pkg::wgt_t      wgt_i,
    output logic              wgt_en_o,
    output sa_pkg::wgt_t      wgt_o,

    input  logic              drain_en_i,
    input  sa_pkg::acc_t      sum_i,
    output logic              drain_en_o,
    output sa_pkg::acc_t      sum_o
);

    sa_pkg::row_ctrl_t row_q;
    sa_pkg::wgt_t      wgt_q;
    sa_pkg::acc_t      prod_q;

    assign row_o = row_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_q      <= '0;
            wgt_en_o   <= 1'b0;
            drain_en_o <= 1'b0;
        end else begin
            row_q      <= row_i;
            wgt_en_o   <= wgt_en_i;
            drain_en_o <= drain_en_i;
        end
    end

    // Product follows the registered copy of the stream.
    always_ff @(posedge clk_i) begin
        if (row_q.bit_vld) begin
            prod_q <= sa_pkg::mac_step(prod_q, wgt_q, row_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wgt_en_i) begin
            wgt_q <= wgt_i;
            wgt_o <= wgt_q;
        end
        // Add this row's product and pass the sum up toward row 0.
        if (drain_en_i) begin
            sum_o <= sum_i + prod_q;
        end
    end

endmodule

// File: rtl/pe_array.sv
module pe_array #(
    parameter int HEIGHT = 4,
    parameter int WIDTH  = 4
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [HEIGHT-1:0]         act_ld_i,
    input  sa_pkg::act_t [HEIGHT-1:0] act_vec_i,
    input  logic [WIDTH-1:0]          wgt_en_i,
    input  sa_pkg::wgt_t [WIDTH-1:0]  wgt_row_i,
    input  logic [WIDTH-1:0]          drain_en_i,
    output sa_pkg::acc_t [WIDTH-1:0]  col_sum_o
);

    // Row stream taken at the output of each PE.
    sa_pkg::row_ctrl_t row_x [HEIGHT][WIDTH];

    // In the column chains index h is the input of row h and index HEIGHT lies below the array.
    sa_pkg::wgt_t wgt_x [WIDTH][HEIGHT+1];
    logic         wen_x [WIDTH][HEIGHT+1];
    sa_pkg::acc_t sum_x [WIDTH][HEIGHT+1];
    logic         den_x [WIDTH][HEIGHT+1];

    for (genvar w = 0; w < WIDTH; w++) begin : g_col
        assign wgt_x[w][0]      = wgt_row_i[w];
        assign wen_x[w][0]      = wgt_en_i[w];
        assign sum_x[w][HEIGHT] = '0;
        assign den_x[w][HEIGHT] = drain_en_i[w];
        assign col_sum_o[w]     = sum_x[w][0];
    end

    for (genvar h = 0; h < HEIGHT; h++) begin : g_row
        pe_border u_pe_border (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .act_ld_i   (act_ld_i[h]),
            .act_i      (act_vec_i[h]),
            .row_o      (row_x[h][0]),
            .wgt_en_i   (wen_x[0][h]),
            .wgt_i      (wgt_x[0][h]),
            .wgt_en_o   (wen_x[0][h+1]),
            .wgt_o      (wgt_x[0][h+1]),
            .drain_en_i (den_x[0][h+1]),
            .sum_i      (sum_x[0][h+1]),
            .drain_en_o (den_x[0][h]),
            .sum_o      (sum_x[0][h])
        );

        for (genvar w = 1; w < WIDTH; w++) begin : g_pe
            pe_inner u_pe_inner (
                .clk_i      (clk_i),
                .arst_n_i   (arst_n_i),
                .row_i      (row_x[h][w-1]),
                .row_o      (row_x[h][w]),
                .wgt_en_i   (wen_x[w][h]),
                .wgt_i      (wgt_x[w][h]),
                .wgt_en_o   (wen_x[w][h+1]),
                .wgt_o      (wgt_x[w][h+1]),
                .drain_en_i (den_x[w][h+1]),
                .sum_i      (sum_x[w][h+1]),
                .drain_en_o (den_x[w][h]),
                .sum_o      (sum_x[w][h])
            );
        end
    end

endmodule

// File: rtl/array_ctrl.sv
module array_ctrl #(
    parameter int HEIGHT = 4,
    parameter int WIDTH  = 4
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  logic                      wgt_req_i,
    input  sa_pkg::wgt_t [WIDTH-1:0]  wgt_row_i,
    output logic                      wgt_ack_o,

    input  logic                      ifm_req_i,
    input  sa_pkg::act_t [HEIGHT-1:0] ifm_vec_i,
    output logic                      ifm_ack_o,

    output logic                      res_req_o,
    output sa_pkg::acc_t [WIDTH-1:0]  res_vec_o,
    input  logic                      res_ack_i,

    output logic [HEIGHT-1:0]         act_ld_o,
    output sa_pkg::act_t [HEIGHT-1:0] act_vec_o,
    output logic [WIDTH-1:0]          wgt_en_o,
    output sa_pkg::wgt_t [WIDTH-1:0]  wgt_row_o,
    output logic [WIDTH-1:0]          drain_en_o,
    input  sa_pkg::acc_t [WIDTH-1:0]  col_sum_i
);

    localparam int CNT_W = $clog2(sa_pkg::IWIDTH + WIDTH + HEIGHT + 1);
    localparam int ROW_W = $clog2(HEIGHT + 1);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [ROW_W-1:0] rows_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD_W,
        WAIT_W,
        ACK_W,
        COMPUTE,
        DRAIN,
        RESULT,
        ACK_V,
        ACK_R
    } state_e;

    state_e state_q;
    cnt_t   cnt_q;
    rows_t  rows_q;
    logic   loaded;
    logic   wgt_start;
    logic   ifm_start;
    logic   res_take;

    assign loaded    = (rows_q == rows_t'(HEIGHT));
    assign wgt_start = (state_q == IDLE) && wgt_req_i;
    assign ifm_start = (state_q == IDLE) && !wgt_req_i && ifm_req_i && loaded;
    assign res_take  = (state_q == DRAIN) && (cnt_q == cnt_t'(HEIGHT));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            cnt_q      <= '0;
            rows_q     <= '0;
            wgt_ack_o  <= 1'b0;
            ifm_ack_o  <= 1'b0;
            res_req_o  <= 1'b0;
            act_ld_o   <= '0;
            wgt_en_o   <= '0;
            drain_en_o <= '0;
        end else begin
            act_ld_o   <= '0;
            wgt_en_o   <= '0;
            drain_en_o <= '0;
            cnt_q      <= cnt_q + 1'b1;

            // The vector handshake closes on its own while the array computes.
            if (ifm_ack_o && !ifm_req_i) begin
                ifm_ack_o <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (wgt_start) begin
                        wgt_en_o <= '1;
                        if (loaded) begin
                            rows_q <= '0; // A full matrix is in place, so this starts a new one.
                        end
                        state_q <= LOAD_W;
                    end else if (ifm_start) begin
                        act_ld_o  <= '1;
                        ifm_ack_o <= 1'b1;
                        state_q   <= COMPUTE;
                    end
                end
                LOAD_W: begin
                    state_q <= WAIT_W;
                end
                WAIT_W: begin
                    if (cnt_q == cnt_t'(HEIGHT - 1)) begin
                        wgt_ack_o <= 1'b1;
                        rows_q    <= rows_q + 1'b1;
                        state_q   <= ACK_W;
                    end
                end
                ACK_W: begin
                    if (!wgt_req_i) begin
                        wgt_ack_o <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
                COMPUTE: begin
                    // Wait until the last bit has passed the last column.
                    if (cnt_q == cnt_t'(sa_pkg::IWIDTH + WIDTH - 1)) begin
                        drain_en_o <= '1;
                        cnt_q      <= '0;
                        state_q    <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (res_take) begin
                        res_req_o <= 1'b1;
                        state_q   <= RESULT;
                    end
                end
                RESULT: begin
                    if (res_ack_i) begin
                        res_req_o <= 1'b0;
                        state_q   <= ACK_R;
                    end
                end
                ACK_R: begin
                    if (!res_ack_i) begin
                        state_q <= ACK_V;
                    end
                end
                ACK_V: begin
                    if (!ifm_ack_o) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wgt_start) begin
            wgt_row_o <= wgt_row_i;
        end
        if (ifm_start) begin
            act_vec_o <= ifm_vec_i;
        end
        if (res_take) begin
            res_vec_o <= col_sum_i; // Held until the next vector drains.
        end
    end

endmodule

// File: rtl/sa_top.sv
module sa_top #(
    parameter int HEIGHT = 4,
    parameter int WIDTH  = 4
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  logic                      wgt_req_i,
    input  sa_pkg::wgt_t [WIDTH-1:0]  wgt_row_i,
    output logic                      wgt_ack_o,

    input  logic                      ifm_req_i,
    input  sa_pkg::act_t [HEIGHT-1:0] ifm_vec_i,
    output logic                      ifm_ack_o,

    output logic                      res_req_o,
    output sa_pkg::acc_t [WIDTH-1:0]  res_vec_o,
    input  logic                      res_ack_i
);

    logic [HEIGHT-1:0]         act_ld;
    sa_pkg::act_t [HEIGHT-1:0] act_vec;
    logic [WIDTH-1:0]          wgt_en;
    sa_pkg::wgt_t [WIDTH-1:0]  wgt_row;
    logic [WIDTH-1:0]          drain_en;
    sa_pkg::acc_t [WIDTH-1:0]  col_sum;

    array_ctrl #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH)
    ) u_array_ctrl (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wgt_req_i  (wgt_req_i),
        .wgt_row_i  (wgt_row_i),
        .wgt_ack_o  (wgt_ack_o),
        .ifm_req_i  (ifm_req_i),
        .ifm_vec_i  (ifm_vec_i),
        .ifm_ack_o  (ifm_ack_o),
        .res_req_o  (res_req_o),
        .res_vec_o  (res_vec_o),
        .res_ack_i  (res_ack_i),
        .act_ld_o   (act_ld),
        .act_vec_o  (act_vec),
        .wgt_en_o   (wgt_en),
        .wgt_row_o  (wgt_row),
        .drain_en_o (drain_en),
        .col_sum_i  (col_sum)
    );

    pe_array #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH)
    ) u_pe_array (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .act_ld_i   (act_ld),
        .act_vec_i  (act_vec),
        .wgt_en_i   (wgt_en),
        .wgt_row_i  (wgt_row),
        .drain_en_i (drain_en),
        .col_sum_o  (col_sum)
    );

endmodule

// File: testbench/tb_sa_top.sv
module tb_sa_top;

    localparam int HEIGHT = 4;
    localparam int WIDTH  = 4;
    // Weight rows plus vector and result exchanges over all tests.
    localparam int HANDSHAKES = 78;
    localparam int MAX_CYCLES = 40 * HANDSHAKES * (sa_pkg::IWIDTH + WIDTH + HEIGHT + 8);

    typedef sa_pkg::act_t [HEIGHT-1:0] act_vec_t;
    typedef sa_pkg::wgt_t [WIDTH-1:0]  wgt_row_t;
    typedef sa_pkg::acc_t [WIDTH-1:0]  res_vec_t;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     wgt_req;
    wgt_row_t wgt_row;
    logic     wgt_ack;
    logic     ifm_req;
    act_vec_t ifm_vec;
    logic     ifm_ack;
    logic     res_req;
    res_vec_t res_vec;
    logic     res_ack;

    sa_pkg::wgt_t wgt_model [HEIGHT][WIDTH]; // Matrix that sits in the array.
    sa_pkg::wgt_t wgt_next  [HEIGHT][WIDTH]; // Matrix for the next load.
    res_vec_t     exp_vec;
    string        cur_test;
    logic         req_seen;
    logic [31:0]  rng_state = 32'd10486;
    int           cycle_cnt = 0;

    always #20 clk = ~clk;

    sa_top #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH)
    ) uut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .wgt_req_i (wgt_req),
        .wgt_row_i (wgt_row),
        .wgt_ack_o (wgt_ack),
        .ifm_req_i (ifm_req),
        .ifm_vec_i (ifm_vec),
        .ifm_ack_o (ifm_ack),
        .res_req_o (res_req),
        .res_vec_o (res_vec),
        .res_ack_i (res_ack)
    );

    task automatic flag_mismatch(string name, res_vec_t expected, res_vec_t actual);
        int col;
        col = 0;
        for (int w = WIDTH - 1; w >= 0; w--) begin
            if (expected[w] !== actual[w]) begin
                col = w;
            end
        end
        $display("FAILED %s column %0d: expected %0d, actual %0d", name, col,
                 $signed(expected[col]), $signed(actual[col]));
        $display("TEST FAILED");
        $fatal(1, "result mismatch");
    endtask

    task automatic abort_run(string what);
        $display("ERROR: %s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            abort_run("timeout, the DUT stopped answering a handshake");
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !req_seen |-> !wgt_ack && !ifm_ack && !res_req)
        else abort_run("a handshake output went high before any request");

    wgt_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wgt_ack) |-> $past(wgt_req))
        else abort_run("wgt_ack_o rose without wgt_req_i");
    wgt_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(wgt_ack) |-> !$past(wgt_req))
        else abort_run("wgt_ack_o fell while wgt_req_i was still high");
    ifm_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ifm_ack) |-> $past(ifm_req))
        else abort_run("ifm_ack_o rose without ifm_req_i");
    ifm_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ifm_ack) |-> !$past(ifm_req))
        else abort_run("ifm_ack_o fell while ifm_req_i was still high");
    res_req_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(res_req) |-> $past(res_ack))
        else abort_run("res_req_o fell before res_ack_i was seen");

    // The result must hold and no new vector may be acknowledged while it waits.
    res_vec_held: assert property (@(posedge clk) disable iff (!arst_n)
        res_req && $past(res_req) |-> $stable(res_vec))
        else abort_run("res_vec_o changed while res_req_o was high");
    res_blocks_acks: assert property (@(posedge clk) disable iff (!arst_n)
        res_req |-> !ifm_ack)
        else abort_run("ifm_ack_o was given while a result was pending");

    res_value: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(res_req) |-> res_vec == exp_vec)
        else flag_mismatch(cur_test, exp_vec, res_vec);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Column w collects act[h] * weight(h, w) over all rows.
    function automatic res_vec_t model_sums(act_vec_t vec);
        res_vec_t sums;
        int       acc;
        for (int w = 0; w < WIDTH; w++) begin
            acc = 0;
            for (int h = 0; h < HEIGHT; h++) begin
                acc += int'($signed(vec[h])) * int'($signed(wgt_model[h][w]));
            end
            sums[w] = sa_pkg::acc_t'(acc);
        end
        return sums;
    endfunction

    function automatic act_vec_t random_vector();
        act_vec_t vec;
        for (int h = 0; h < HEIGHT; h++) begin
            vec[h] = sa_pkg::act_t'(xorshift32() >> 24);
        end
        return vec;
    endfunction

    function automatic act_vec_t extreme_vector(int pattern);
        act_vec_t vec;
        for (int h = 0; h < HEIGHT; h++) begin
            case (pattern)
                0:       vec[h] = 8'sh80;
                1:       vec[h] = 8'sh7f;
                2:       vec[h] = (h % 2 == 0) ? 8'sh80 : 8'sh7f;
                default: vec[h] = (h % 2 == 0) ? 8'sh7f : 8'sh80;
            endcase
        end
        return vec;
    endfunction

    function automatic void fill_random_weights();
        for (int h = 0; h < HEIGHT; h++) begin
            for (int w = 0; w < WIDTH; w++) begin
                wgt_next[h][w] = sa_pkg::wgt_t'(xorshift32() >> 24);
            end
        end
    endfunction

    function automatic void fill_extreme_weights();
        for (int h = 0; h < HEIGHT; h++) begin
            for (int w = 0; w < WIDTH; w++) begin
                wgt_next[h][w] = ((h * WIDTH + w) % 3 == 0) ? 8'sh7f : 8'sh80;
            end
        end
    endfunction

    // Last row first, since the first row pushed ends up at the bottom.
    task automatic load_weights();
        wgt_row_t row;
        for (int h = HEIGHT - 1; h >= 0; h--) begin
            for (int w = 0; w < WIDTH; w++) begin
                row[w] = wgt_next[h][w];
            end
            wgt_row  = row;
            wgt_req  = 1'b1;
            req_seen = 1'b1;
            while (wgt_ack !== 1'b1) @(negedge clk);
            wgt_req = 1'b0;
            while (wgt_ack !== 1'b0) @(negedge clk);
        end
        wgt_model = wgt_next;
    endtask

    task automatic send_vector(act_vec_t vec);
        exp_vec  = model_sums(vec);
        ifm_vec  = vec;
        ifm_req  = 1'b1;
        req_seen = 1'b1;
        while (ifm_ack !== 1'b1) @(negedge clk);
        ifm_req = 1'b0;
        while (ifm_ack !== 1'b0) @(negedge clk);
    endtask

    task automatic take_result(int delay);
        while (res_req !== 1'b1) @(negedge clk);
        repeat (delay) @(negedge clk);
        res_ack = 1'b1;
        while (res_req !== 1'b0) @(negedge clk);
        res_ack = 1'b0;
    endtask

    task automatic run_vector(act_vec_t vec, int delay);
        send_vector(vec);
        take_result(delay);
    endtask

    // A second vector waits on the channel while the first result is held back.
    task automatic queue_during_result(int delay);
        act_vec_t next_vec;
        send_vector(random_vector());
        while (res_req !== 1'b1) @(negedge clk);
        next_vec = random_vector();
        ifm_vec  = next_vec;
        ifm_req  = 1'b1;
        repeat (delay) @(negedge clk);
        res_ack = 1'b1;
        while (res_req !== 1'b0) @(negedge clk);
        res_ack = 1'b0;
        exp_vec = model_sums(next_vec);
        while (ifm_ack !== 1'b1) @(negedge clk);
        ifm_req = 1'b0;
        while (ifm_ack !== 1'b0) @(negedge clk);
        take_result(0);
    endtask

    initial begin
        arst_n   = 1'b0;
        wgt_req  = 1'b0;
        wgt_row  = '0;
        ifm_req  = 1'b0;
        ifm_vec  = '0;
        res_ack  = 1'b0;
        exp_vec  = '0;
        req_seen = 1'b0;
        cur_test = "reset";
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (5) @(negedge clk);

        cur_test = "random weights";
        fill_random_weights();
        load_weights();
        repeat (20) begin
            run_vector(random_vector(), 0);
        end

        cur_test = "extreme values";
        fill_extreme_weights();
        load_weights();
        for (int p = 0; p < 4; p++) begin
            run_vector(extreme_vector(p), 0);
        end

        cur_test = "reload";
        fill_random_weights();
        load_weights();
        repeat (5) begin
            run_vector(random_vector(), 0);
        end

        cur_test = "back-pressure";
        repeat (2) begin
            run_vector(random_vector(), int'(xorshift32() % 16) + 1);
        end
        queue_during_result(int'(xorshift32() % 16) + 1);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: sources.f
rtl/sa_pkg.sv
rtl/pe_border.sv
rtl/pe_inner.sv
rtl/pe_array.sv
rtl/array_ctrl.sv
rtl/sa_top.sv
testbench/tb_sa_top.sv

// File: Bender.yml
package:
  name: systolic_array

sources:
  - rtl/sa_pkg.sv
  - rtl/pe_border.sv
  - rtl/pe_inner.sv
  - rtl/pe_array.sv
  - rtl/array_ctrl.sv
  - rtl/sa_top.sv
  - target: test
    files:
      - testbench/tb_sa_top.sv
